// File: verilog/priv_csr_pkg.sv
`default_nettype none

// Machine-mode CSR layouts and the privilege level encoding
package priv_csr_pkg;

    // Architectural privilege encodings, 2'b10 is reserved
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_level_t;

    // Target of a software CSR write
    typedef enum logic [1:0] {
        CSR_NONE    = 2'b00,
        CSR_MSTATUS = 2'b01,
        CSR_MIE     = 2'b10
    } csr_sel_t;

    // Only the M-mode trap stack fields are implemented
    typedef struct packed {
        logic [13:0] reserved_31_18;
        logic        mprv;              // Bit 17
        logic [3:0]  reserved_16_13;
        priv_level_t mpp;               // Bits 12:11
        logic [2:0]  reserved_10_8;
        logic        mpie;              // Bit 7
        logic [2:0]  reserved_6_4;
        logic        mie;               // Bit 3
        logic [2:0]  reserved_2_0;
    } mstatus_t;

    // Pending bits, S-level ones are recorded only
    typedef struct packed {
        logic [19:0] reserved_31_12;
        logic        meip;              // Bit 11
        logic        reserved_10;
        logic        seip;              // Bit 9
        logic        reserved_8;
        logic        mtip;              // Bit 7
        logic        reserved_6;
        logic        stip;              // Bit 5
        logic        reserved_4;
        logic        msip;              // Bit 3
        logic        reserved_2;
        logic        ssip;              // Bit 1
        logic        reserved_0;
    } mip_t;

    // Enable bits, same positions as mip
    typedef struct packed {
        logic [19:0] reserved_31_12;
        logic        meie;
        logic        reserved_10;
        logic        seie;
        logic        reserved_8;
        logic        mtie;
        logic        reserved_6;
        logic        stie;
        logic        reserved_4;
        logic        msie;
        logic        reserved_2;
        logic        ssie;
        logic        reserved_0;
    } mie_t;

    typedef struct packed {
        logic        interrupt;         // Set for asynchronous causes
        logic [30:0] cause;
    } mcause_t;

endpackage

`default_nettype wire

// File: verilog/priv_trap_pkg.sv
`default_nettype none

// Trap cause codes and the request structs passed between the trap blocks
package priv_trap_pkg;

    // Synchronous exception codes
    typedef enum logic [30:0] {
        INSN_MAL     = 31'd0,
        INSN_ACCESS  = 31'd1,
        ILLEGAL_INSN = 31'd2,
        BREAKPOINT   = 31'd3,
        L_ADDR_MAL   = 31'd4,
        L_FAULT      = 31'd5,
        S_ADDR_MAL   = 31'd6,
        S_FAULT      = 31'd7,
        ENV_CALL_U   = 31'd8,
        ENV_CALL_S   = 31'd9,
        ENV_CALL_M   = 31'd11,
        INSN_PAGE    = 31'd12,
        LOAD_PAGE    = 31'd13,
        STORE_PAGE   = 31'd15
    } ex_code_t;

    // Interrupt codes, same numbering as the mip bits
    typedef enum logic [30:0] {
        SOFT_INT_S  = 31'd1,
        SOFT_INT_M  = 31'd3,
        TIMER_INT_S = 31'd5,
        TIMER_INT_M = 31'd7,
        EXT_INT_S   = 31'd9,
        EXT_INT_M   = 31'd11
    } int_code_t;

    // One pulse per source, used for both set and clear
    typedef struct packed {
        logic ext_m;
        logic soft_m;
        logic timer_m;
        logic ext_s;
        logic soft_s;
        logic timer_s;
    } int_lines_t;

    // Exception flags raised by the pipeline in the faulting cycle
    typedef struct packed {
        logic       insn_mal;
        logic       insn_access;
        logic       illegal_insn;
        logic       breakpoint;
        logic       l_addr_mal;
        logic       l_fault;
        logic       s_addr_mal;
        logic       s_fault;
        logic       env_u;
        logic       env_s;
        logic       env_m;
        logic       insn_page;
        logic       load_page;
        logic       store_page;
        logic       rmgmt;              // Resource manager fault
        logic [4:0] rmgmt_cause;        // Cause code supplied by the manager
    } ex_flags_t;

    typedef struct packed {
        logic     valid;
        ex_code_t code;
        logic     has_tval;             // mtval is written for this cause
    } ex_result_t;

    typedef struct packed {
        logic      valid;
        int_code_t code;
    } int_result_t;

endpackage

`default_nettype wire

// File: verilog/int_pending_unit.sv
`timescale 1ns/1ps
`default_nettype none

module int_pending_unit
    import priv_csr_pkg::*, priv_trap_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        rst_n,
    input  int_lines_t       int_set,
    input  int_lines_t       int_clr,
    input  csr_sel_t         csr_sel,
    input  wire logic        csr_wen,
    input  wire logic [31:0] csr_wdata,
    input  wire logic        global_mie,
    output mip_t             mip,
    output mie_t             mie,
    output int_result_t      int_result
);

    mip_t next_mip;
    mie_t next_mie;
    logic ext_en, soft_en, timer_en;

    // Set pulse has priority over clear for the same bit
    always_comb begin
        next_mip = mip;
        if (int_set.ext_m)        next_mip.meip = 1'b1;
        else if (int_clr.ext_m)   next_mip.meip = 1'b0;
        if (int_set.soft_m)       next_mip.msip = 1'b1;
        else if (int_clr.soft_m)  next_mip.msip = 1'b0;
        if (int_set.timer_m)      next_mip.mtip = 1'b1;
        else if (int_clr.timer_m) next_mip.mtip = 1'b0;
        if (int_set.ext_s)        next_mip.seip = 1'b1;
        else if (int_clr.ext_s)   next_mip.seip = 1'b0;
        if (int_set.soft_s)       next_mip.ssip = 1'b1;
        else if (int_clr.soft_s)  next_mip.ssip = 1'b0;
        if (int_set.timer_s)      next_mip.stip = 1'b1;
        else if (int_clr.timer_s) next_mip.stip = 1'b0;
    end

    always_comb begin
        next_mie = mie;
        if (csr_wen && (csr_sel == CSR_MIE)) begin
            next_mie      = '0;             // Reserved bits read zero
            next_mie.meie = csr_wdata[11];
            next_mie.seie = csr_wdata[9];
            next_mie.mtie = csr_wdata[7];
            next_mie.stie = csr_wdata[5];
            next_mie.msie = csr_wdata[3];
            next_mie.ssie = csr_wdata[1];
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
            mie <= '0;
        end else begin
            mip <= next_mip;
            mie <= next_mie;
        end
    end

    // Machine sources only, S-level bits never fire here
    assign ext_en   = mip.meip & mie.meie;
    assign soft_en  = mip.msip & mie.msie;
    assign timer_en = mip.mtip & mie.mtie;

    always_comb begin
        int_result.valid = global_mie & (ext_en | soft_en | timer_en);
        if (ext_en)
            int_result.code = EXT_INT_M;
        else if (soft_en)
            int_result.code = SOFT_INT_M;
        else
            int_result.code = TIMER_INT_M;  // Also the idle value
    end

    a_valid_needs_gie : assert property (@(posedge CLK) disable iff (!rst_n)
        int_result.valid |-> global_mie);

endmodule

`default_nettype wire

// File: verilog/ex_priority_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ex_priority_encoder
    import priv_trap_pkg::*;
(
    input  ex_flags_t  ex_flags,
    output ex_result_t ex_result
);

    // Fixed chain, instruction side faults rank first
    always_comb begin
        ex_result.valid    = 1'b1;
        ex_result.code     = INSN_MAL;
        ex_result.has_tval = 1'b1;

        if (ex_flags.breakpoint) begin
            ex_result.code = BREAKPOINT;
        end else if (ex_flags.insn_page) begin
            ex_result.code     = INSN_PAGE;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.insn_access) begin
            ex_result.code = INSN_ACCESS;
        end else if (ex_flags.illegal_insn) begin
            ex_result.code = ILLEGAL_INSN;
        end else if (ex_flags.insn_mal) begin
            ex_result.code = INSN_MAL;
        end else if (ex_flags.env_u) begin
            ex_result.code     = ENV_CALL_U;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.env_s) begin
            ex_result.code     = ENV_CALL_S;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.env_m) begin
            ex_result.code     = ENV_CALL_M;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.s_addr_mal) begin
            ex_result.code = S_ADDR_MAL;
        end else if (ex_flags.l_addr_mal) begin
            ex_result.code = L_ADDR_MAL;
        end else if (ex_flags.store_page) begin
            ex_result.code     = STORE_PAGE;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.load_page) begin
            ex_result.code     = LOAD_PAGE;
            ex_result.has_tval = 1'b0;
        end else if (ex_flags.s_fault) begin
            ex_result.code = S_FAULT;
        end else if (ex_flags.l_fault) begin
            ex_result.code = L_FAULT;
        end else if (ex_flags.rmgmt) begin
            // Manager supplies its own code
            ex_result.code = ex_code_t'({26'd0, ex_flags.rmgmt_cause});
        end else begin
            ex_result.valid    = 1'b0;
            ex_result.has_tval = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
    import priv_csr_pkg::*, priv_trap_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire logic            CLK,
    input  wire logic            rst_n,
    input  ex_result_t           ex_result,
    input  int_result_t          int_result,
    input  wire logic [XLEN-1:0] epc,
    input  wire logic [XLEN-1:0] tval,
    input  wire logic            mret,
    input  csr_sel_t             csr_sel,
    input  wire logic            csr_wen,
    input  wire logic [31:0]     csr_wdata,
    output logic                 trap,
    output mcause_t              trap_cause,
    output logic                 global_mie,
    output mstatus_t             mstatus,
    output mcause_t              mcause,
    output logic [XLEN-1:0]      mepc,
    output logic [XLEN-1:0]      mtval,
    output priv_level_t          priv_level
);

    mstatus_t    next_mstatus;
    priv_level_t next_priv;
    logic [30:0] ex_cause, int_cause;

    // Interrupt result is already gated by mstatus.mie
    assign global_mie = mstatus.mie;
    assign trap       = ex_result.valid | int_result.valid;

    assign ex_cause  = ex_result.code;
    assign int_cause = int_result.code;

    // Exception wins over a pending interrupt
    assign trap_cause.interrupt = ~ex_result.valid & int_result.valid;
    assign trap_cause.cause     = ex_result.valid ? ex_cause : int_cause;

    always_comb begin
        next_mstatus = mstatus;
        next_priv    = priv_level;
        if (trap) begin
            next_mstatus.mpie = mstatus.mie;
            next_mstatus.mie  = 1'b0;
            next_mstatus.mpp  = priv_level;
            next_priv         = M_MODE;
        end else if (mret) begin
            next_mstatus.mie  = mstatus.mpie;
            next_mstatus.mpie = 1'b0;
            next_mstatus.mpp  = U_MODE;     // Least privileged mode
            next_priv         = mstatus.mpp;
            if (mstatus.mpp != M_MODE)
                next_mstatus.mprv = 1'b0;
        end else if (csr_wen && (csr_sel == CSR_MSTATUS)) begin
            next_mstatus.mprv = csr_wdata[17];
            next_mstatus.mpie = csr_wdata[7];
            next_mstatus.mie  = csr_wdata[3];
            // Reserved mpp encoding keeps the old value
            if (csr_wdata[12:11] != 2'b10)
                next_mstatus.mpp = priv_level_t'(csr_wdata[12:11]);
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            mstatus    <= '0;
            priv_level <= M_MODE;
        end else begin
            mstatus    <= next_mstatus;
            priv_level <= next_priv;
        end
    end

    // Trap record registers
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
            mepc   <= '0;
            mtval  <= '0;
        end else if (trap) begin
            mcause <= trap_cause;
            mepc   <= epc;
            if (ex_result.valid && ex_result.has_tval)
                mtval <= tval;              // Faulting address or instruction
        end
    end

    a_ex_not_int : assert property (@(posedge CLK) disable iff (!rst_n)
        ex_result.valid |-> !trap_cause.interrupt);

endmodule

`default_nettype wire

// File: verilog/priv_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module priv_trap_unit
    import priv_csr_pkg::*, priv_trap_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire logic            CLK,
    input  wire logic            rst_n,
    input  int_lines_t           int_set,
    input  int_lines_t           int_clr,
    input  ex_flags_t            ex_flags,
    input  wire logic [XLEN-1:0] epc,
    input  wire logic [XLEN-1:0] tval,
    input  wire logic            mret,
    input  csr_sel_t             csr_sel,
    input  wire logic            csr_wen,
    input  wire logic [31:0]     csr_wdata,
    output logic                 trap,
    output mcause_t              trap_cause,
    output mstatus_t             mstatus,
    output mie_t                 mie,
    output mip_t                 mip,
    output mcause_t              mcause,
    output logic [XLEN-1:0]      mepc,
    output logic [XLEN-1:0]      mtval,
    output priv_level_t          priv_level
);

    int_result_t int_result;
    ex_result_t  ex_result;
    logic        global_mie;       // mstatus.mie fed back to the interrupt gate

    int_pending_unit i_int_pending_unit (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .int_set    (int_set),
        .int_clr    (int_clr),
        .csr_sel    (csr_sel),
        .csr_wen    (csr_wen),
        .csr_wdata  (csr_wdata),
        .global_mie (global_mie),
        .mip        (mip),
        .mie        (mie),
        .int_result (int_result)
    );

    ex_priority_encoder i_ex_priority_encoder (
        .ex_flags  (ex_flags),
        .ex_result (ex_result)
    );

    trap_ctrl #(
        .XLEN (XLEN)
    ) i_trap_ctrl (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .ex_result  (ex_result),
        .int_result (int_result),
        .epc        (epc),
        .tval       (tval),
        .mret       (mret),
        .csr_sel    (csr_sel),
        .csr_wen    (csr_wen),
        .csr_wdata  (csr_wdata),
        .trap       (trap),
        .trap_cause (trap_cause),
        .global_mie (global_mie),
        .mstatus    (mstatus),
        .mcause     (mcause),
        .mepc       (mepc),
        .mtval      (mtval),
        .priv_level (priv_level)
    );

endmodule

`default_nettype wire

// File: dv/priv_trap_checks.svh
`ifndef PRIV_TRAP_CHECKS_SVH
`define PRIV_TRAP_CHECKS_SVH

// Compare tasks, one per result type of the DUT
task automatic check_mcause(input mcause_t got, input mcause_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_mstatus(input mstatus_t got, input mstatus_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_mip(input mip_t got, input mip_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_mie(input mie_t got, input mie_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_priv(input priv_level_t got, input priv_level_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %s expected %s", $time, what, got.name(), exp.name());
        stop_run();
    end
endtask

// For mepc and mtval, which are XLEN wide
task automatic check_xlen(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("FAIL at %0t ns: %s got %b expected %b", $time, what, got, exp);
        stop_run();
    end
endtask

`endif

// File: dv/priv_trap_tb.sv
`timescale 1ns/1ps
`default_nettype none

module priv_trap_tb
    import priv_csr_pkg::*, priv_trap_pkg::*;
;
    localparam int XLEN = 32;

    logic CLK, rst_n, mret, csr_wen, trap;
    int_lines_t int_set, int_clr;
    ex_flags_t ex_flags;
    logic [XLEN-1:0] epc, tval, mepc, mtval, exp_mtval, v_epc, v_tval;
    csr_sel_t csr_sel;
    logic [31:0] csr_wdata;
    mcause_t trap_cause, mcause;
    mstatus_t mstatus;
    mie_t mie;
    mip_t mip;
    priv_level_t priv_level;

    `include "priv_trap_checks.svh"

    priv_trap_unit #(.XLEN(XLEN)) i_dut (
        .CLK(CLK), .rst_n(rst_n), .int_set(int_set), .int_clr(int_clr),
        .ex_flags(ex_flags), .epc(epc), .tval(tval), .mret(mret),
        .csr_sel(csr_sel), .csr_wen(csr_wen), .csr_wdata(csr_wdata),
        .trap(trap), .trap_cause(trap_cause), .mstatus(mstatus), .mie(mie), .mip(mip),
        .mcause(mcause), .mepc(mepc), .mtval(mtval), .priv_level(priv_level)
    );

    always #5 CLK = ~CLK;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Advance to the next falling edge and drop every one-cycle pulse
    task automatic next_cycle();
        @(negedge CLK);
        {int_set, int_clr, ex_flags, mret, csr_wen} = '0;
    endtask

    task automatic csr_write(input csr_sel_t sel, input logic [31:0] data);
        csr_sel   = sel;
        csr_wen   = 1'b1;
        csr_wdata = data;
    endtask

    task automatic wait_trap(input int limit);
        int cnt;
        cnt = 0;
        #1;
        while (!trap) begin
            if (cnt == limit) begin
                $display("Timeout: no trap within %0d cycles", limit);
                stop_run();
            end
            @(negedge CLK);
            #1;
            cnt++;
        end
    endtask

    function automatic mstatus_t make_mstatus(logic mprv, priv_level_t mpp, logic mpie, logic ie);
        mstatus_t s;
        s      = '0;
        s.mprv = mprv;
        s.mpp  = mpp;
        s.mpie = mpie;
        s.mie  = ie;
        return s;
    endfunction

    function automatic mcause_t make_cause(logic irq, logic [30:0] code);
        mcause_t c;
        c.interrupt = irq;
        c.cause     = code;
        return c;
    endfunction

    // Rank 0 is the highest priority exception
    function automatic ex_flags_t add_flag(ex_flags_t f, int rank);
        case (rank)
            0:  f.breakpoint   = 1'b1;
            1:  f.insn_page    = 1'b1;
            2:  f.insn_access  = 1'b1;
            3:  f.illegal_insn = 1'b1;
            4:  f.insn_mal     = 1'b1;
            5:  f.env_u        = 1'b1;
            6:  f.env_s        = 1'b1;
            7:  f.env_m        = 1'b1;
            8:  f.s_addr_mal   = 1'b1;
            9:  f.l_addr_mal   = 1'b1;
            10: f.store_page   = 1'b1;
            11: f.load_page    = 1'b1;
            12: f.s_fault      = 1'b1;
            13: f.l_fault      = 1'b1;
            default: f.rmgmt   = 1'b1;
        endcase
        return f;
    endfunction

    function automatic logic [30:0] rank_code(int rank, logic [4:0] rc);
        case (rank)
            0:  return BREAKPOINT;
            1:  return INSN_PAGE;
            2:  return INSN_ACCESS;
            3:  return ILLEGAL_INSN;
            4:  return INSN_MAL;
            5:  return ENV_CALL_U;
            6:  return ENV_CALL_S;
            7:  return ENV_CALL_M;
            8:  return S_ADDR_MAL;
            9:  return L_ADDR_MAL;
            10: return STORE_PAGE;
            11: return LOAD_PAGE;
            12: return S_FAULT;
            13: return L_FAULT;
            default: return {26'd0, rc};
        endcase
    endfunction

    // Page faults and ecalls carry no trap value
    function automatic logic rank_has_tval(int rank);
        return !(rank == 1 || (rank >= 5 && rank <= 7) || rank == 10 || rank == 11);
    endfunction

    // Present an exception now, check trap_cause, then the records one cycle later
    task automatic take_exception(input ex_flags_t flags, input logic [30:0] code, input logic tv);
        v_epc    = $urandom;
        v_tval   = $urandom;
        ex_flags = flags;
        epc      = v_epc;
        tval     = v_tval;
        #1;
        check_bit(trap, 1'b1, "trap on exception");
        check_mcause(trap_cause, make_cause(1'b0, code), "trap_cause");
        next_cycle();
        if (tv)
            exp_mtval = v_tval;
        check_mcause(mcause, make_cause(1'b0, code), "mcause");
        check_xlen(mepc, v_epc, "mepc");
        check_xlen(mtval, exp_mtval, "mtval");
    endtask

    task automatic test_reset();
        #1;
        check_bit(trap, 1'b0, "trap after reset");
        check_mstatus(mstatus, '0, "mstatus after reset");
        check_mie(mie, '0, "mie after reset");
        check_mip(mip, '0, "mip after reset");
        check_mcause(mcause, '0, "mcause after reset");
        check_xlen(mepc, '0, "mepc after reset");
        check_xlen(mtval, '0, "mtval after reset");
        check_priv(priv_level, M_MODE, "priv_level after reset");
    endtask

    task automatic test_ex_priority();
        int i, k, r, best;
        ex_flags_t flags;
        logic [4:0] rc;
        for (i = 0; i < 40; i++) begin
            flags             = '0;
            rc                = 5'($urandom % 32);
            flags.rmgmt_cause = rc;
            best              = 15;
            for (k = 0; k < 2 + (i % 2); k++) begin    // Pairs and triples
                r     = $urandom % 15;
                flags = add_flag(flags, r);
                if (r < best)
                    best = r;
            end
            take_exception(flags, rank_code(best, rc), rank_has_tval(best));
        end
    endtask

    task automatic expect_interrupt(input logic [30:0] code);
        v_epc = $urandom;
        epc   = v_epc;
        wait_trap(4);
        check_mcause(trap_cause, make_cause(1'b1, code), "interrupt trap_cause");
        next_cycle();
        check_mcause(mcause, make_cause(1'b1, code), "interrupt mcause");
        check_xlen(mepc, v_epc, "interrupt mepc");
        check_mstatus(mstatus, make_mstatus(1'b0, M_MODE, 1'b1, 1'b0), "mstatus on interrupt");
    endtask

    task automatic test_interrupts();
        mip_t exp_mip;
        mie_t exp_mie;
        int j;
        exp_mip = '0;
        {exp_mip.meip, exp_mip.msip, exp_mip.mtip} = 3'b111;
        {exp_mip.seip, exp_mip.ssip, exp_mip.stip} = 3'b111;
        exp_mie = '0;
        {exp_mie.meie, exp_mie.msie, exp_mie.mtie} = 3'b111;
        {exp_mie.seie, exp_mie.ssie, exp_mie.stie} = 3'b111;
        int_set = '1;
        csr_write(CSR_MSTATUS, 32'h8);                  // Global enable alone
        next_cycle();
        #1;
        check_mip(mip, exp_mip, "mip after set pulses");
        check_bit(trap, 1'b0, "trap with mie clear");
        next_cycle();
        csr_write(CSR_MSTATUS, 32'h0);
        next_cycle();
        csr_write(CSR_MIE, 32'h0000_0aaa);              // S enables too
        next_cycle();
        #1;
        check_mie(mie, exp_mie, "mie after write");
        check_bit(trap, 1'b0, "trap with global mie clear");
        next_cycle();
        csr_write(CSR_MSTATUS, 32'h8);
        next_cycle();
        expect_interrupt(EXT_INT_M);
        int_clr.ext_m = 1'b1;
        csr_write(CSR_MSTATUS, 32'h8);
        next_cycle();
        expect_interrupt(SOFT_INT_M);
        int_clr.soft_m = 1'b1;
        csr_write(CSR_MSTATUS, 32'h8);
        next_cycle();
        expect_interrupt(TIMER_INT_M);
        int_clr.timer_m = 1'b1;
        csr_write(CSR_MSTATUS, 32'h8);
        next_cycle();
        for (j = 0; j < 3; j++) begin                   // Only S bits left pending
            #1;
            check_bit(trap, 1'b0, "trap from S-level bit");
            @(negedge CLK);
        end
        {exp_mip.meip, exp_mip.msip, exp_mip.mtip} = 3'b000;
        check_mip(mip, exp_mip, "mip with S bits only");
        int_clr = '1;
        csr_write(CSR_MSTATUS, 32'h0);
        next_cycle();
        csr_write(CSR_MIE, 32'h0);
        next_cycle();
        check_mip(mip, '0, "mip after clears");
    endtask

    task automatic test_ex_over_int();
        ex_flags_t flags;
        mip_t exp_mip;
        mie_t exp_mie;
        int_set.ext_m = 1'b1;
        csr_write(CSR_MIE, 32'h0000_0800);
        next_cycle();
        csr_write(CSR_MSTATUS, 32'h8);
        next_cycle();
        exp_mip      = '0;
        exp_mip.meip = 1'b1;
        exp_mie      = '0;
        exp_mie.meie = 1'b1;
        check_mip(mip, exp_mip, "mip with ext pending");
        check_mie(mie, exp_mie, "mie with ext enabled");
        check_mstatus(mstatus, make_mstatus(1'b0, U_MODE, 1'b0, 1'b1), "mstatus global on");
        flags              = '0;
        flags.illegal_insn = 1'b1;
        take_exception(flags, ILLEGAL_INSN, 1'b1);
        int_clr.ext_m = 1'b1;
        csr_write(CSR_MIE, 32'h0);
        next_cycle();
        check_mip(mip, '0, "mip after ext clear");
    endtask

    task automatic test_trap_mret();
        ex_flags_t flags;
        csr_write(CSR_MSTATUS, 32'h0002_0080);          // mprv, mpie, mpp=U
        next_cycle();
        mret = 1'b1;
        next_cycle();
        check_mstatus(mstatus, make_mstatus(1'b0, U_MODE, 1'b0, 1'b1), "mstatus entering U");
        check_priv(priv_level, U_MODE, "priv_level entering U");
        flags       = '0;
        flags.env_u = 1'b1;
        take_exception(flags, ENV_CALL_U, 1'b0);
        check_mstatus(mstatus, make_mstatus(1'b0, U_MODE, 1'b1, 1'b0), "mstatus after trap");
        check_priv(priv_level, M_MODE, "priv_level after trap");
        csr_write(CSR_MSTATUS, 32'h0002_0080);
        next_cycle();
        mret = 1'b1;
        next_cycle();
        check_mstatus(mstatus, make_mstatus(1'b0, U_MODE, 1'b0, 1'b1), "mstatus after mret");
        check_priv(priv_level, U_MODE, "priv_level after mret");
    endtask

    initial begin
        void'($urandom(32'hfaa));
        CLK       = 1'b0;
        rst_n     = 1'b0;
        {int_set, int_clr, ex_flags, mret, csr_wen} = '0;
        csr_sel   = CSR_NONE;
        csr_wdata = '0;
        epc       = '0;
        tval      = '0;
        exp_mtval = '0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_reset();
        next_cycle();
        test_ex_priority();
        test_interrupts();
        test_ex_over_int();
        test_trap_mret();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
verilog/priv_csr_pkg.sv
verilog/priv_trap_pkg.sv
verilog/int_pending_unit.sv
verilog/ex_priority_encoder.sv
verilog/trap_ctrl.sv
verilog/priv_trap_unit.sv
dv/priv_trap_tb.sv
